//--- include/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data and address width
`define LSU_XLEN 32

// word-address bits of the on-chip memory, 1024 words
`define LSU_MEM_AW 10

// cycles from AR handshake to rvalid
`define LSU_READ_LAT 2

// cycles from W handshake to bvalid
`define LSU_WRITE_LAT 1

`endif

//--- lsu_mem.f
+incdir+include
rtl/lsu_pkg.sv
rtl/load_channel.sv
rtl/store_channel.sv
rtl/lsu_core.sv
rtl/axi_sram.sv
rtl/lsu_mem_top.sv
test/tb_lsu_mem.sv

//--- rtl/axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module axi_sram (
    input  wire                         clk,
    input  wire                         rst,
    input  wire [`LSU_XLEN-1:0]         araddr,
    input  wire                         arvalid,
    output logic                        arready,
    output logic [`LSU_XLEN-1:0]        rdata_bus,
    output lsu_pkg::bus_resp_e          rresp,
    output logic                        rvalid,
    input  wire                         rready,
    input  wire [`LSU_XLEN-1:0]         awaddr,
    input  wire                         awvalid,
    output logic                        awready,
    input  wire [`LSU_XLEN-1:0]         wdata_bus,
    input  wire [`LSU_XLEN/8-1:0]       wstrb,
    input  wire                         wvalid,
    output logic                        wready,
    output lsu_pkg::bus_resp_e          bresp,
    output logic                        bvalid,
    input  wire                         bready
);

    localparam int DEPTH  = 1 << `LSU_MEM_AW;
    localparam int STRB_W = `LSU_XLEN / 8;

    logic [`LSU_XLEN-1:0]   mem [DEPTH];
    lsu_pkg::slave_state_e  rd_state;
    lsu_pkg::slave_state_e  wr_state;
    logic [7:0]             rd_cnt;
    logic [7:0]             wr_cnt;
    logic                   aw_held;
    logic [`LSU_XLEN-1:0]   wr_addr;

    // word index must fit in the array
    function automatic logic in_range(input logic [`LSU_XLEN-1:0] a);
        in_range = (a[`LSU_XLEN-1:`LSU_MEM_AW+2] == '0);
    endfunction

    assign arready = (rd_state == lsu_pkg::S_IDLE);
    assign awready = (wr_state == lsu_pkg::S_IDLE) & ~aw_held;
    assign wready  = (wr_state == lsu_pkg::S_IDLE) & aw_held;

    // read data is sampled at the AR handshake and shown after the latency
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata_bus <= in_range(araddr) ? mem[araddr[`LSU_MEM_AW+1:2]] : '0;
            rresp     <= in_range(araddr) ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_DECERR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= lsu_pkg::S_IDLE;
            rd_cnt   <= '0;
            rvalid   <= 1'b0;
        end else begin
            case (rd_state)
                lsu_pkg::S_IDLE: begin
                    if (arvalid) begin
                        if (`LSU_READ_LAT > 1) begin
                            rd_cnt   <= 8'(`LSU_READ_LAT - 1);
                            rd_state <= lsu_pkg::S_WAIT;
                        end else begin
                            rvalid   <= 1'b1;
                            rd_state <= lsu_pkg::S_ACK;
                        end
                    end
                end
                lsu_pkg::S_WAIT: begin
                    rd_cnt <= rd_cnt - 8'd1;
                    if (rd_cnt == 8'd1) begin
                        rvalid   <= 1'b1;
                        rd_state <= lsu_pkg::S_ACK;
                    end
                end
                default: begin
                    if (rready) begin
                        rvalid   <= 1'b0;
                        rd_state <= lsu_pkg::S_IDLE;
                    end
                end
            endcase
        end
    end

    // write address capture, then strobed byte update on W
    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            wr_addr <= awaddr;
        end
        if (wvalid && wready) begin
            bresp <= in_range(wr_addr) ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_DECERR;
            if (in_range(wr_addr)) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (wstrb[b]) begin
                        mem[wr_addr[`LSU_MEM_AW+1:2]][8*b +: 8] <= wdata_bus[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= lsu_pkg::S_IDLE;
            wr_cnt   <= '0;
            aw_held  <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            case (wr_state)
                lsu_pkg::S_IDLE: begin
                    if (awvalid && !aw_held) begin
                        aw_held <= 1'b1;
                    end else if (wvalid && aw_held) begin
                        aw_held <= 1'b0;
                        if (`LSU_WRITE_LAT > 1) begin
                            wr_cnt   <= 8'(`LSU_WRITE_LAT - 1);
                            wr_state <= lsu_pkg::S_WAIT;
                        end else begin
                            bvalid   <= 1'b1;
                            wr_state <= lsu_pkg::S_ACK;
                        end
                    end
                end
                lsu_pkg::S_WAIT: begin
                    wr_cnt <= wr_cnt - 8'd1;
                    if (wr_cnt == 8'd1) begin
                        bvalid   <= 1'b1;
                        wr_state <= lsu_pkg::S_ACK;
                    end
                end
                default: begin
                    if (bready) begin
                        bvalid   <= 1'b0;
                        wr_state <= lsu_pkg::S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/load_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module load_channel (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         start,
    input  wire                         sign,
    input  wire lsu_pkg::mem_size_e     size,
    input  wire [`LSU_XLEN-1:0]         addr,
    output logic [`LSU_XLEN-1:0]        araddr,
    output logic                        arvalid,
    input  wire                         arready,
    input  wire [`LSU_XLEN-1:0]         rdata_bus,
    input  wire lsu_pkg::bus_resp_e     rresp,
    input  wire                         rvalid,
    output logic                        rready,
    output logic                        done,
    output lsu_pkg::bus_resp_e          resp,
    output logic [`LSU_XLEN-1:0]        load_data
);

    lsu_pkg::chan_state_e   state;
    lsu_pkg::mem_size_e     size_q;
    logic                   sign_q;
    logic [`LSU_XLEN-1:0]   shifted;
    logic [`LSU_XLEN-1:0]   extracted;

    // one access at a time, always ready for the answer
    assign rready = 1'b1;
    assign done   = (state == lsu_pkg::DONE);

    // move the addressed byte down to lane 0, then pick size and extend
    always_comb begin
        shifted = rdata_bus >> {araddr[1:0], 3'b000};
        case (size_q)
            lsu_pkg::SIZE_BYTE: extracted = {{(`LSU_XLEN-8){sign_q & shifted[7]}}, shifted[7:0]};
            lsu_pkg::SIZE_HALF: extracted = {{(`LSU_XLEN-16){sign_q & shifted[15]}},
                                             shifted[15:0]};
            lsu_pkg::SIZE_WORD: extracted = shifted;
            default:            extracted = '0;
        endcase
    end

    // request capture
    always_ff @(posedge clk) begin
        if (state == lsu_pkg::IDLE && start) begin
            araddr <= addr;
            size_q <= size;
            sign_q <= sign;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= lsu_pkg::IDLE;
            arvalid   <= 1'b0;
            resp      <= lsu_pkg::RESP_OKAY;
            load_data <= '0;
        end else begin
            case (state)
                lsu_pkg::IDLE: begin
                    if (start) begin
                        arvalid <= 1'b1;
                        state   <= lsu_pkg::ADDR;
                    end
                end
                lsu_pkg::ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state   <= lsu_pkg::DATA;
                    end
                end
                lsu_pkg::DATA: begin
                    if (rvalid && rready) begin
                        load_data <= extracted;
                        resp      <= rresp;
                        state     <= lsu_pkg::DONE;
                    end
                end
                // done is high for this one cycle
                default: state <= lsu_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/lsu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_core (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         req,
    input  wire                         wen,
    input  wire                         ren,
    input  wire                         sign,
    input  wire lsu_pkg::mem_size_e     size,
    input  wire [`LSU_XLEN-1:0]         addr,
    input  wire [`LSU_XLEN-1:0]         wdata,
    output logic [`LSU_XLEN-1:0]        rdata,
    output logic                        valid,
    output logic                        err,
    // read bus
    output logic [`LSU_XLEN-1:0]        araddr,
    output logic                        arvalid,
    input  wire                         arready,
    input  wire [`LSU_XLEN-1:0]         rdata_bus,
    input  wire lsu_pkg::bus_resp_e     rresp,
    input  wire                         rvalid,
    output logic                        rready,
    // write bus
    output logic [`LSU_XLEN-1:0]        awaddr,
    output logic                        awvalid,
    input  wire                         awready,
    output logic [`LSU_XLEN-1:0]        wdata_bus,
    output logic [`LSU_XLEN/8-1:0]      wstrb,
    output logic                        wvalid,
    input  wire                         wready,
    input  wire lsu_pkg::bus_resp_e     bresp,
    input  wire                         bvalid,
    output logic                        bready
);

    logic               ld_start;
    logic               st_start;
    logic               ld_done;
    logic               st_done;
    lsu_pkg::bus_resp_e ld_resp;
    lsu_pkg::bus_resp_e st_resp;
    logic               last_store;

    // req is already a single-cycle strobe
    assign ld_start = req & ren;
    assign st_start = req & wen;

    // remember which channel answered last, err follows its response
    always_ff @(posedge clk) begin
        if (rst) begin
            last_store <= 1'b0;
        end else if (st_start) begin
            last_store <= 1'b1;
        end else if (ld_start) begin
            last_store <= 1'b0;
        end
    end

    assign err = last_store ? (st_resp == lsu_pkg::RESP_DECERR)
                            : (ld_resp == lsu_pkg::RESP_DECERR);

    // no access requested, complete at once
    assign valid = (wen | ren) ? (ld_done | st_done) : req;

    load_channel u_load (
        .clk(clk), .rst(rst), .start(ld_start), .sign(sign), .size(size), .addr(addr),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata_bus(rdata_bus), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .done(ld_done), .resp(ld_resp), .load_data(rdata)
    );

    store_channel u_store (
        .clk(clk), .rst(rst), .start(st_start), .size(size), .addr(addr), .wdata(wdata),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata_bus(wdata_bus), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .done(st_done), .resp(st_resp)
    );

endmodule

`default_nettype wire

//--- rtl/lsu_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_mem_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         req,
    input  wire                         wen,
    input  wire                         ren,
    input  wire                         sign,
    input  wire lsu_pkg::mem_size_e     size,
    input  wire [`LSU_XLEN-1:0]         addr,
    input  wire [`LSU_XLEN-1:0]         wdata,
    output logic [`LSU_XLEN-1:0]        rdata,
    output logic                        valid,
    output logic                        err
);

    // internal bus between the unit and the memory
    logic [`LSU_XLEN-1:0]   araddr;
    logic                   arvalid;
    logic                   arready;
    logic [`LSU_XLEN-1:0]   rdata_bus;
    lsu_pkg::bus_resp_e     rresp;
    logic                   rvalid;
    logic                   rready;
    logic [`LSU_XLEN-1:0]   awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [`LSU_XLEN-1:0]   wdata_bus;
    logic [`LSU_XLEN/8-1:0] wstrb;
    logic                   wvalid;
    logic                   wready;
    lsu_pkg::bus_resp_e     bresp;
    logic                   bvalid;
    logic                   bready;

    lsu_core u_core (
        .clk(clk), .rst(rst), .req(req), .wen(wen), .ren(ren), .sign(sign),
        .size(size), .addr(addr), .wdata(wdata),
        .rdata(rdata), .valid(valid), .err(err),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata_bus(rdata_bus), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata_bus(wdata_bus), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

    axi_sram u_sram (
        .clk(clk), .rst(rst),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata_bus(rdata_bus), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata_bus(wdata_bus), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

endmodule

`default_nettype wire

//--- rtl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // access size, same coding as the pipeline mask
    typedef enum logic [1:0] {
        SIZE_NONE = 2'b00,
        SIZE_BYTE = 2'b01,
        SIZE_HALF = 2'b10,
        SIZE_WORD = 2'b11
    } mem_size_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } bus_resp_e;

    // master channel states
    typedef enum logic [2:0] {
        IDLE,
        ADDR,
        DATA,
        RESP,
        DONE
    } chan_state_e;

    // memory slave states, one copy per channel
    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_ACK
    } slave_state_e;

endpackage

`default_nettype wire

//--- rtl/store_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module store_channel (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         start,
    input  wire lsu_pkg::mem_size_e     size,
    input  wire [`LSU_XLEN-1:0]         addr,
    input  wire [`LSU_XLEN-1:0]         wdata,
    output logic [`LSU_XLEN-1:0]        awaddr,
    output logic                        awvalid,
    input  wire                         awready,
    output logic [`LSU_XLEN-1:0]        wdata_bus,
    output logic [`LSU_XLEN/8-1:0]      wstrb,
    output logic                        wvalid,
    input  wire                         wready,
    input  wire lsu_pkg::bus_resp_e     bresp,
    input  wire                         bvalid,
    output logic                        bready,
    output logic                        done,
    output lsu_pkg::bus_resp_e          resp
);

    localparam int STRB_W = `LSU_XLEN / 8;

    lsu_pkg::chan_state_e   state;
    logic [STRB_W-1:0]      strb;
    logic [`LSU_XLEN-1:0]   lanes;

    assign bready = 1'b1;
    assign done   = (state == lsu_pkg::DONE);

    // byte lane placement and strobe from the low address bits
    always_comb begin
        lanes = wdata << {addr[1:0], 3'b000};
        case (size)
            lsu_pkg::SIZE_BYTE: strb = STRB_W'(1) << addr[1:0];
            lsu_pkg::SIZE_HALF: strb = STRB_W'(2'b11) << {addr[1], 1'b0};
            lsu_pkg::SIZE_WORD: strb = '1;
            default:            strb = '0;
        endcase
    end

    // address, data and strobe are held for the whole access
    always_ff @(posedge clk) begin
        if (state == lsu_pkg::IDLE && start) begin
            awaddr    <= addr;
            wdata_bus <= lanes;
            wstrb     <= strb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= lsu_pkg::IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            resp    <= lsu_pkg::RESP_OKAY;
        end else begin
            case (state)
                lsu_pkg::IDLE: begin
                    if (start) begin
                        awvalid <= 1'b1;
                        state   <= lsu_pkg::ADDR;
                    end
                end
                // W follows AW, never together
                lsu_pkg::ADDR: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b1;
                        state   <= lsu_pkg::DATA;
                    end
                end
                lsu_pkg::DATA: begin
                    if (wready) begin
                        wvalid <= 1'b0;
                        state  <= lsu_pkg::RESP;
                    end
                end
                lsu_pkg::RESP: begin
                    if (bvalid && bready) begin
                        resp  <= bresp;
                        state <= lsu_pkg::DONE;
                    end
                end
                default: state <= lsu_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build the LSU testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f lsu_mem.f --top-module tb_lsu_mem \
    --Mdir obj_dir -o tb_lsu_mem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_lsu_mem > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi

cat sim.log
if grep -q "^Testbench passed$" sim.log; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi

//--- test/tb_lsu_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module tb_lsu_mem;

    localparam int WAIT_LIMIT = 64;
    localparam int MEM_BYTES  = 4 << `LSU_MEM_AW;

    logic                   clk   = 1'b0;
    logic                   rst   = 1'b1;
    logic                   req   = 1'b0;
    logic                   wen   = 1'b0;
    logic                   ren   = 1'b0;
    logic                   sign  = 1'b0;
    lsu_pkg::mem_size_e     size  = lsu_pkg::SIZE_NONE;
    logic [`LSU_XLEN-1:0]   addr  = '0;
    logic [`LSU_XLEN-1:0]   wdata = '0;
    logic [`LSU_XLEN-1:0]   rdata;
    logic                   valid;
    logic                   err;

    // reference copy of the memory, one entry per byte
    logic [7:0]             ref_mem [MEM_BYTES];
    logic [`LSU_XLEN-1:0]   exp_rdata    = '0;
    logic                   exp_err      = 1'b0;
    logic                   chk_data     = 1'b0;
    logic                   chk_err      = 1'b0;
    logic                   outstanding  = 1'b0;
    int                     errors       = 0;
    int                     proto_errors = 0;
    int                     base_errors  = 0;
    int                     tests        = 0;
    integer                 seed;

    lsu_mem_top dut (
        .clk(clk), .rst(rst), .req(req), .wen(wen), .ren(ren), .sign(sign),
        .size(size), .addr(addr), .wdata(wdata),
        .rdata(rdata), .valid(valid), .err(err)
    );

    always #5 clk = ~clk;

    // an access stays open from its req until its valid
    always @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (valid) begin
            outstanding <= 1'b0;
        end else if (req) begin
            outstanding <= 1'b1;
        end
    end

    // outputs on the first clock after reset is released
    assert property (@(posedge clk) $fell(rst) |-> (valid == 1'b0))
        else begin
            errors++;
            $display("ERROR valid after reset expected %h actual %h", 1'b0, $sampled(valid));
        end
    assert property (@(posedge clk) $fell(rst) |-> (err == 1'b0))
        else begin
            errors++;
            $display("ERROR err after reset expected %h actual %h", 1'b0, $sampled(err));
        end
    assert property (@(posedge clk) $fell(rst) |-> (rdata == '0))
        else begin
            errors++;
            $display("ERROR rdata after reset expected %h actual %h", 32'h0, $sampled(rdata));
        end

    assert property (@(posedge clk) disable iff (rst) (req && !wen && !ren) |-> valid)
        else begin
            proto_errors++;
            $display("valid did not follow a request that asked for no access");
        end
    assert property (@(posedge clk) disable iff (rst) valid |-> (req || outstanding))
        else begin
            proto_errors++;
            $display("valid rose with no request open");
        end
    assert property (@(posedge clk) disable iff (rst) valid |=> !valid)
        else begin
            proto_errors++;
            $display("valid stayed high for more than one cycle");
        end

    assert property (@(posedge clk) disable iff (rst) (valid && chk_data) |-> (rdata == exp_rdata))
        else begin
            errors++;
            $display("ERROR rdata expected %h actual %h", $sampled(exp_rdata), $sampled(rdata));
        end
    assert property (@(posedge clk) disable iff (rst) (valid && chk_err) |-> (err == exp_err))
        else begin
            errors++;
            $display("ERROR err expected %h actual %h", $sampled(exp_err), $sampled(err));
        end

    function automatic logic addr_fits(input logic [`LSU_XLEN-1:0] a);
        addr_fits = (a < MEM_BYTES);
    endfunction

    function automatic logic [31:0] ref_word(input logic [`LSU_XLEN-1:0] a);
        logic [`LSU_MEM_AW-1:0] w;
        w = a[`LSU_MEM_AW+1:2];
        ref_word = {ref_mem[{w, 2'd3}], ref_mem[{w, 2'd2}],
                    ref_mem[{w, 2'd1}], ref_mem[{w, 2'd0}]};
    endfunction

    // expected load result: shift down, pick the size, extend
    function automatic logic [31:0] load_expect(input logic [`LSU_XLEN-1:0] a,
                                                input lsu_pkg::mem_size_e sz, input logic s);
        logic [31:0] word;
        word = '0;
        if (addr_fits(a)) begin
            word = ref_word(a) >> (8 * a[1:0]);
        end
        case (sz)
            lsu_pkg::SIZE_BYTE: load_expect = {{24{s & word[7]}}, word[7:0]};
            lsu_pkg::SIZE_HALF: load_expect = {{16{s & word[15]}}, word[15:0]};
            lsu_pkg::SIZE_WORD: load_expect = word;
            default:            load_expect = '0;
        endcase
    endfunction

    task automatic store_model(input logic [`LSU_XLEN-1:0] a, input lsu_pkg::mem_size_e sz,
                               input logic [31:0] d);
        logic [31:0] lanes;
        logic [3:0]  strb;
        lanes = d << (8 * a[1:0]);
        case (sz)
            lsu_pkg::SIZE_BYTE: strb = 4'b0001 << a[1:0];
            lsu_pkg::SIZE_HALF: strb = a[1] ? 4'b1100 : 4'b0011;
            lsu_pkg::SIZE_WORD: strb = 4'b1111;
            default:            strb = 4'b0000;
        endcase
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                ref_mem[{a[`LSU_MEM_AW+1:2], 2'(b)}] = lanes[8*b +: 8];
            end
        end
    endtask

    // one req pulse, then wait for valid, sampled away from the clock edge
    task automatic run_access(input logic w, input logic r, input logic s,
                              input lsu_pkg::mem_size_e sz,
                              input logic [`LSU_XLEN-1:0] a, input logic [`LSU_XLEN-1:0] d);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        @(posedge clk);
        req   <= 1'b1;
        wen   <= w;
        ren   <= r;
        sign  <= s;
        size  <= sz;
        addr  <= a;
        wdata <= d;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            seen = valid;
            @(posedge clk);
            req <= 1'b0;
            cycles++;
        end
        wen <= 1'b0;
        ren <= 1'b0;
        if (!seen) begin
            $display("timeout: no valid within %0d cycles of the request to address %h",
                     WAIT_LIMIT, a);
            $display("Testbench failed");
            $finish;
        end
    endtask

    task automatic do_store(input lsu_pkg::mem_size_e sz, input logic [`LSU_XLEN-1:0] a,
                            input logic [`LSU_XLEN-1:0] d);
        exp_err  = !addr_fits(a);
        chk_data = 1'b0;
        chk_err  = 1'b1;
        if (addr_fits(a)) begin
            store_model(a, sz, d);
        end
        run_access(1'b1, 1'b0, 1'b0, sz, a, d);
    endtask

    task automatic do_load(input lsu_pkg::mem_size_e sz, input logic s,
                           input logic [`LSU_XLEN-1:0] a);
        exp_err   = !addr_fits(a);
        exp_rdata = load_expect(a, sz, s);
        chk_data  = 1'b1;
        chk_err   = 1'b1;
        run_access(1'b0, 1'b1, s, sz, a, '0);
    endtask

    // one more clock so the checks of the last access have reported
    task automatic finish_test(input int num, input string name);
        @(posedge clk);
        $display("test %0d %s: %0d errors", num, name, errors - base_errors);
        base_errors = errors;
        tests++;
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] far;
        seed = 32'hf4b4ca9f;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        chk_data = 1'b0;
        chk_err  = 1'b0;
        run_access(1'b0, 1'b0, 1'b0, lsu_pkg::SIZE_NONE, 32'h0, 32'h0);
        run_access(1'b0, 1'b0, 1'b1, lsu_pkg::SIZE_WORD, 32'h40, 32'h1234);
        finish_test(1, "reset and empty request");

        for (int i = 0; i < 8; i++) begin
            a = $random(seed) & 32'h0000_0ffc;
            d = $random(seed);
            do_store(lsu_pkg::SIZE_WORD, a, d);
            do_load(lsu_pkg::SIZE_WORD, 1'b0, a);
        end
        finish_test(2, "word store and load");

        a = $random(seed) & 32'h0000_0ffc;
        do_store(lsu_pkg::SIZE_WORD, a, $random(seed));
        for (int off = 0; off < 4; off++) begin
            do_store(lsu_pkg::SIZE_BYTE, a + 32'(off), $random(seed));
            do_load(lsu_pkg::SIZE_WORD, 1'b0, a);
        end
        for (int off = 0; off < 4; off++) begin
            do_store(lsu_pkg::SIZE_HALF, a + 32'(off), $random(seed));
            do_load(lsu_pkg::SIZE_WORD, 1'b0, a);
        end
        finish_test(3, "byte and half stores");

        for (int pass = 0; pass < 2; pass++) begin
            a = $random(seed) & 32'h0000_0ffc;
            d = $random(seed);
            // top bit of every byte clear on the first pass, set on the second
            d = (pass == 0) ? (d & 32'h7f7f_7f7f) : (d | 32'h8080_8080);
            do_store(lsu_pkg::SIZE_WORD, a, d);
            for (int off = 0; off < 4; off++) begin
                for (int s = 0; s < 2; s++) begin
                    do_load(lsu_pkg::SIZE_BYTE, s[0], a + 32'(off));
                    do_load(lsu_pkg::SIZE_HALF, s[0], a + 32'(off));
                end
            end
        end
        finish_test(4, "byte and half loads");

        a = $random(seed) & 32'h0000_0ffc;
        d = $random(seed);
        do_store(lsu_pkg::SIZE_WORD, a, d);
        // same low bits, word index past the end
        far = a | ({$random(seed)} << 12) | 32'h0000_1000;
        do_store(lsu_pkg::SIZE_WORD, far, ~d);
        do_load(lsu_pkg::SIZE_WORD, 1'b0, a);
        do_store(lsu_pkg::SIZE_BYTE, far + 32'd1, 32'h5a);
        do_load(lsu_pkg::SIZE_WORD, 1'b0, far);
        do_load(lsu_pkg::SIZE_HALF, 1'b1, far + 32'd2);
        do_load(lsu_pkg::SIZE_WORD, 1'b0, a);
        finish_test(5, "out of range accesses");

        @(posedge clk);
        $display("test 6 valid pulse protocol: %0d errors", proto_errors);
        tests++;

        $display("%0d tests, %0d value errors, %0d protocol errors",
                 tests, errors, proto_errors);
        if (errors == 0 && proto_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
